// ==== Makefile ====
# Verilator build and run for the address path testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_ar_subsystem
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_LOG   := sim.log
PASS_MSG  := ** PASS **

SOURCES   := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides the result, the simulator exit code alone is not trusted
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@grep -qF '$(PASS_MSG)' $(SIM_LOG) || { echo "simulation failed, see $(SIM_LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== address_register.sv ====
// the 24-bit address register, loaded from the internal bus plus extension byte or stepped by one
`include "cft_defines.svh"

module address_register (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   ar_load,
   input  logic                   ar_inc,
   input  logic [`CFT_IBUS_W-1:0] ar_data,
   input  logic [`CFT_AEXT_W-1:0] ar_ext,
   output cft_bus_pkg::addr_t     ar
);

   ////////////////////
   // next address
   ////////////////////

   cft_bus_pkg::addr_t ar_loaded;
   cft_bus_pkg::addr_t ar_stepped;

   // the extension register gives the bank byte on top of the data word
   assign ar_loaded = {ar_ext, ar_data};

   // block transfers step through the whole 24-bit space
   // the add is done at full width so the top address rolls over to zero
   assign ar_stepped = ar + 1'b1;

   ////////////////////
   // the register
   ////////////////////

   // the sequencer never raises both strobes together, load wins anyway
   // nothing changes while a bus cycle runs because no strobes arrive then
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ar <= '0;
      end else if (ar_load) begin
         ar <= ar_loaded;
      end else if (ar_inc) begin
         ar <= ar_stepped;
      end
   end

endmodule

// ==== ar_subsystem.sv ====
// top level of the address path, connects the command sequencer, the address register and the bus driver
`include "cft_defines.svh"

module ar_subsystem (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   cmd_valid,
   input  cft_ctl_pkg::cmd_e      cmd_code,
   input  logic [`CFT_IBUS_W-1:0] ibus,
   input  logic [`CFT_AEXT_W-1:0] aext,
   input  cft_ctl_pkg::fp_sel_e   fp_sel,
   output cft_bus_pkg::addr_t     ab,
   output logic                   ab_en,
   output logic                   mem_rd,
   output logic                   mem_wr,
   output logic                   io_rd,
   output logic                   io_wr,
   output logic [3:0]             dev_sel_n,
   output logic [`CFT_AEXT_W-1:0] fpd,
   output cft_bus_pkg::addr_t     ar,
   output logic                   cycle_done,
   output logic                   cmd_drop
);

   ////////////////////
   // internal nets
   ////////////////////

   // strobes and load data from the sequencer to the register
   logic                   ar_load;
   logic                   ar_inc;
   logic [`CFT_IBUS_W-1:0] ar_data;
   logic [`CFT_AEXT_W-1:0] ar_ext;

   // cycle state from the sequencer to the bus driver
   logic                   cycle_active;
   cft_ctl_pkg::cycle_e    cycle_kind;

   // sequencer, decides what each command does and times the bus cycle
   cycle_decode u_cycle_decode (
      .clk          (clk),
      .arst_n       (arst_n),
      .cmd_valid    (cmd_valid),
      .cmd_code     (cmd_code),
      .ibus         (ibus),
      .aext         (aext),
      .ar_load      (ar_load),
      .ar_inc       (ar_inc),
      .cycle_active (cycle_active),
      .cmd_drop     (cmd_drop),
      .ar_data      (ar_data),
      .ar_ext       (ar_ext),
      .cycle_kind   (cycle_kind)
   );

   // the address register itself
   address_register u_address_register (
      .clk     (clk),
      .arst_n  (arst_n),
      .ar_load (ar_load),
      .ar_inc  (ar_inc),
      .ar_data (ar_data),
      .ar_ext  (ar_ext),
      .ar      (ar)
   );

   // bus side, the address bus, strobes, I/O group selects and front panel
   bus_drive u_bus_drive (
      .clk          (clk),
      .arst_n       (arst_n),
      .cycle_active (cycle_active),
      .cycle_kind   (cycle_kind),
      .ar           (ar),
      .fp_sel       (fp_sel),
      .ab           (ab),
      .ab_en        (ab_en),
      .mem_rd       (mem_rd),
      .mem_wr       (mem_wr),
      .io_rd        (io_rd),
      .io_wr        (io_wr),
      .cycle_done   (cycle_done),
      .dev_sel_n    (dev_sel_n),
      .fpd          (fpd)
   );

endmodule

// ==== bus_drive.sv ====
// drives the address bus, memory and I/O strobes, I/O device-group selects and the front-panel byte
`include "cft_defines.svh"

module bus_drive (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   cycle_active,
   input  cft_ctl_pkg::cycle_e    cycle_kind,
   input  cft_bus_pkg::addr_t     ar,
   input  cft_ctl_pkg::fp_sel_e   fp_sel,
   output cft_bus_pkg::addr_t     ab,
   output logic                   ab_en,
   output logic                   mem_rd,
   output logic                   mem_wr,
   output logic                   io_rd,
   output logic                   io_wr,
   output logic                   cycle_done,
   output logic [3:0]             dev_sel_n,
   output logic [`CFT_AEXT_W-1:0] fpd
);

   // the decoder serves the system group and groups 1xx to 3xx, higher groups are left free
   localparam int NUM_DEV_GRP = 4;

   cft_bus_pkg::addr_u ar_view;
   logic               io_cycle;
   logic               io_hit;
   logic [3:0]         dev_sel_d;
   logic               active_q;

   assign ar_view = ar;

   ////////////////////
   // I/O decode
   ////////////////////

   assign io_cycle = (cycle_kind == cft_ctl_pkg::CYC_IO_RD) ||
                     (cycle_kind == cft_ctl_pkg::CYC_IO_WR);

   // only the bottom 2K of I/O space reaches the group decoder
   assign io_hit = cycle_active && io_cycle && (ar_view.io.high == '0);

   // one active-low select per group, like a 3-to-8 demux with the top outputs unused
   always_comb begin
      dev_sel_d = '1;
      if (io_hit && (ar_view.io.dev_grp < NUM_DEV_GRP)) begin
         dev_sel_d[ar_view.io.dev_grp[1:0]] = 1'b0;
      end
   end

   ////////////////////
   // bus outputs
   ////////////////////

   // everything on the bus is registered, so it trails cycle_active by a clock
   // outside a cycle the bus reads zero in place of a floating bus
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         active_q   <= 1'b0;
         ab         <= '0;
         mem_rd     <= 1'b0;
         mem_wr     <= 1'b0;
         io_rd      <= 1'b0;
         io_wr      <= 1'b0;
         dev_sel_n  <= '1;
         cycle_done <= 1'b0;
      end else begin
         active_q   <= cycle_active;
         ab         <= cycle_active ? ar_view.mem : '0;
         mem_rd     <= cycle_active && (cycle_kind == cft_ctl_pkg::CYC_MEM_RD);
         mem_wr     <= cycle_active && (cycle_kind == cft_ctl_pkg::CYC_MEM_WR);
         io_rd      <= cycle_active && (cycle_kind == cft_ctl_pkg::CYC_IO_RD);
         io_wr      <= cycle_active && (cycle_kind == cft_ctl_pkg::CYC_IO_WR);
         dev_sel_n  <= dev_sel_d;
         // falling edge of the delayed activity marks the end of the bus cycle
         cycle_done <= active_q & ~cycle_active;
      end
   end

   // the bus is enabled exactly while the registered cycle is active
   assign ab_en = active_q;

   ////////////////////
   // front panel
   ////////////////////

   // the panel watches the register itself, not the bus, so it is live between cycles too
   always_comb begin
      case (fp_sel)
         cft_ctl_pkg::FP_LOW:  fpd = ar_view.mem.offset[7:0];
         cft_ctl_pkg::FP_MID:  fpd = ar_view.mem.offset[15:8];
         cft_ctl_pkg::FP_HIGH: fpd = ar_view.mem.bank;
         default:              fpd = '0;
      endcase
   end

endmodule

// ==== cft_bus_pkg.sv ====
// address word types for the address path, shared by the register, the bus driver and the top level
`include "cft_defines.svh"

package cft_bus_pkg;

   ////////////////////
   // plain address
   ////////////////////

   // one address word as held in the address register and driven on the bus
   typedef logic [`CFT_ADDR_W-1:0] addr_t;

   ////////////////////
   // memory view
   ////////////////////

   // memory space is linear, the bank byte comes from the extension register
   // and the offset from the internal bus
   typedef struct packed {
      logic [`CFT_AEXT_W-1:0] bank;
      logic [`CFT_IBUS_W-1:0] offset;
   } mem_addr_s;

   ////////////////////
   // I/O view
   ////////////////////

   // I/O space only decodes the low 16 bits
   // the top byte is ignored, bits 15 to 11 must be zero for any device to respond,
   // bits 10 to 8 pick a device group and the low byte is left to the device itself
   typedef struct packed {
      logic [`CFT_AEXT_W-1:0] ext;
      logic [4:0]             high;
      logic [2:0]             dev_grp;
      logic [7:0]             dev_reg;
   } io_addr_s;

   // the same address word read either as a memory address or as an I/O address
   // both views are exactly one address wide
   typedef union packed {
      mem_addr_s mem;
      io_addr_s  io;
   } addr_u;

endpackage

// ==== cft_ctl_pkg.sv ====
// command, cycle kind and front-panel select encodings used between the sequencer and the bus driver
`include "cft_defines.svh"

package cft_ctl_pkg;

   ////////////////////
   // command codes
   ////////////////////

   // codes on the command port, only valid while cmd_valid is high
   // LOAD_AR and INC_AR act on the register, the rest start a bus cycle
   typedef enum logic [`CFT_CMD_W-1:0] {
      IDLE    = 3'd0,
      LOAD_AR = 3'd1,
      INC_AR  = 3'd2,
      MEM_RD  = 3'd3,
      MEM_WR  = 3'd4,
      IO_RD   = 3'd5,
      IO_WR   = 3'd6
   } cmd_e;

   ////////////////////
   // cycle kind
   ////////////////////

   // the bus cycle currently running, CYC_NONE between cycles
   // names carry a prefix so they do not clash with the command codes above
   typedef enum logic [2:0] {
      CYC_NONE   = 3'd0,
      CYC_MEM_RD = 3'd1,
      CYC_MEM_WR = 3'd2,
      CYC_IO_RD  = 3'd3,
      CYC_IO_WR  = 3'd4
   } cycle_e;

   // which byte of the address register the front panel shows
   typedef enum logic [1:0] {
      FP_LOW  = 2'd0,
      FP_MID  = 2'd1,
      FP_HIGH = 2'd2
   } fp_sel_e;

endpackage

// ==== cft_defines.svh ====
// shared widths and bus cycle timing for the address path, include it in any file that sizes a port
`ifndef CFT_DEFINES_SVH
`define CFT_DEFINES_SVH

////////////////////
// bus widths
////////////////////

// the full address bus, a bank byte above a 16-bit offset
`define CFT_ADDR_W 24

// the internal data bus feeds the low part of the address register
`define CFT_IBUS_W 16

// the extension register supplies the top byte of the address
`define CFT_AEXT_W 8

////////////////////
// sequencing
////////////////////

// every memory and I/O cycle lasts this many clocks, there are no wait states
`define CFT_BUS_CYCLE_LEN 4

// width of the command code on the command port
`define CFT_CMD_W 3

`endif

// ==== cycle_decode.sv ====
// command sequencer, turns command strobes into register strobes or timed bus cycles and drops commands while busy
`include "cft_defines.svh"

module cycle_decode (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   cmd_valid,
   input  cft_ctl_pkg::cmd_e      cmd_code,
   input  logic [`CFT_IBUS_W-1:0] ibus,
   input  logic [`CFT_AEXT_W-1:0] aext,
   output logic                   ar_load,
   output logic                   ar_inc,
   output logic                   cycle_active,
   output logic                   cmd_drop,
   output logic [`CFT_IBUS_W-1:0] ar_data,
   output logic [`CFT_AEXT_W-1:0] ar_ext,
   output cft_ctl_pkg::cycle_e    cycle_kind
);

   // the counter has to hold the full cycle length
   localparam int CNT_W = $clog2(`CFT_BUS_CYCLE_LEN + 1);

   logic [CNT_W-1:0]    cyc_cnt;
   logic                accept;
   logic                is_bus_cmd;
   logic                drop_pend;
   cft_ctl_pkg::cycle_e kind_d;

   // busy for as long as there are clocks left in the running cycle
   assign cycle_active = (cyc_cnt != '0);

   // a strobe is only taken when no cycle is running, there is no back-pressure
   assign accept = cmd_valid & ~cycle_active;

   // map the bus commands onto the cycle kind they start
   always_comb begin
      is_bus_cmd = 1'b1;
      kind_d     = cft_ctl_pkg::CYC_NONE;
      case (cmd_code)
         cft_ctl_pkg::MEM_RD: kind_d = cft_ctl_pkg::CYC_MEM_RD;
         cft_ctl_pkg::MEM_WR: kind_d = cft_ctl_pkg::CYC_MEM_WR;
         cft_ctl_pkg::IO_RD:  kind_d = cft_ctl_pkg::CYC_IO_RD;
         cft_ctl_pkg::IO_WR:  kind_d = cft_ctl_pkg::CYC_IO_WR;
         default:             is_bus_cmd = 1'b0;
      endcase
   end

   ////////////////////
   // cycle timer
   ////////////////////

   // loading the counter raises cycle_active in the next clock, it then stays
   // high for exactly CFT_BUS_CYCLE_LEN clocks
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cyc_cnt    <= '0;
         cycle_kind <= cft_ctl_pkg::CYC_NONE;
      end else if (accept && is_bus_cmd) begin
         cyc_cnt    <= CNT_W'(`CFT_BUS_CYCLE_LEN);
         cycle_kind <= kind_d;
      end else if (cycle_active) begin
         cyc_cnt <= cyc_cnt - 1'b1;
         // the kind goes back to none together with cycle_active
         if (cyc_cnt == CNT_W'(1)) begin
            cycle_kind <= cft_ctl_pkg::CYC_NONE;
         end
      end
   end

   ////////////////////
   // register strobes
   ////////////////////

   // one-clock strobes to the address register, the register updates at the
   // end of that clock so the new address shows two clocks after the command
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ar_load <= 1'b0;
         ar_inc  <= 1'b0;
      end else begin
         ar_load <= accept && (cmd_code == cft_ctl_pkg::LOAD_AR);
         ar_inc  <= accept && (cmd_code == cft_ctl_pkg::INC_AR);
      end
   end

   // the load data is captured with the command so it lines up with ar_load
   always_ff @(posedge clk) begin
      if (accept && (cmd_code == cft_ctl_pkg::LOAD_AR)) begin
         ar_data <= ibus;
         ar_ext  <= aext;
      end
   end

   // any strobe during a cycle is lost, even register commands, since the
   // address must not move under a running bus cycle
   // the flag comes out two clocks after the strobe
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         drop_pend <= 1'b0;
         cmd_drop  <= 1'b0;
      end else begin
         drop_pend <= cmd_valid & cycle_active;
         cmd_drop  <= drop_pend;
      end
   end

endmodule

// ==== tb.f ====
+incdir+.
cft_bus_pkg.sv
cft_ctl_pkg.sv
cycle_decode.sv
address_register.sv
bus_drive.sv
ar_subsystem.sv
tb_ar_subsystem.sv

// ==== tb_ar_subsystem.sv ====
// self-checking testbench for the address path top level that the Makefile builds and runs
`include "cft_defines.svh"

module tb_ar_subsystem;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_DIRECTED = 64;
   localparam int NUM_RANDOM   = 200;
   localparam int NUM_CMDS     = NUM_DIRECTED + NUM_RANDOM;
   localparam int BUS_LEN      = `CFT_BUS_CYCLE_LEN;
   // longest time one command may take is the strobe plus the whole bus cycle and its done pulse
   localparam int CMD_CYCLES   = BUS_LEN + 4;
   localparam int WATCHDOG_T   = (RESET_CYCLES + 20 + NUM_CMDS * CMD_CYCLES) * CLK_PERIOD;

   logic                   clk;
   logic                   arst_n;
   logic                   cmd_valid;
   cft_ctl_pkg::cmd_e      cmd_code;
   logic [`CFT_IBUS_W-1:0] ibus;
   logic [`CFT_AEXT_W-1:0] aext;
   cft_ctl_pkg::fp_sel_e   fp_sel;
   cft_bus_pkg::addr_t     ab;
   logic                   ab_en;
   logic                   mem_rd;
   logic                   mem_wr;
   logic                   io_rd;
   logic                   io_wr;
   logic [3:0]             dev_sel_n;
   logic [`CFT_AEXT_W-1:0] fpd;
   cft_bus_pkg::addr_t     ar;
   logic                   cycle_done;
   logic                   cmd_drop;

   integer seed;
   string  test_name;

   ar_subsystem DUT (
      .clk        (clk),
      .arst_n     (arst_n),
      .cmd_valid  (cmd_valid),
      .cmd_code   (cmd_code),
      .ibus       (ibus),
      .aext       (aext),
      .fp_sel     (fp_sel),
      .ab         (ab),
      .ab_en      (ab_en),
      .mem_rd     (mem_rd),
      .mem_wr     (mem_wr),
      .io_rd      (io_rd),
      .io_wr      (io_wr),
      .dev_sel_n  (dev_sel_n),
      .fpd        (fpd),
      .ar         (ar),
      .cycle_done (cycle_done),
      .cmd_drop   (cmd_drop)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // the run must not outlive every command taking its longest possible time
   initial begin
      #(WATCHDOG_T);
      $display("watchdog expired, the run took longer than %0d time units", WATCHDOG_T);
      $display("** FAIL **");
      $fatal(1, "watchdog timeout");
   end

   ////////////////////
   // helpers
   ////////////////////

   function automatic logic is_bus_cmd(input cft_ctl_pkg::cmd_e code);
      return code inside {cft_ctl_pkg::MEM_RD, cft_ctl_pkg::MEM_WR,
                          cft_ctl_pkg::IO_RD, cft_ctl_pkg::IO_WR};
   endfunction

   // a group answers only when bits 15 to 11 are zero and groups 4 to 7 have no select line
   function automatic logic [3:0] group_select(input cft_bus_pkg::addr_t addr);
      logic [3:0] sel;
      sel = 4'hf;
      if ((addr[15:11] == 5'd0) && (addr[10:8] < 3'd4)) begin
         sel[addr[9:8]] = 1'b0;
      end
      return sel;
   endfunction

   task automatic report_mismatch(input string what, input logic [23:0] expected,
                                  input logic [23:0] actual);
      $display("mismatch in test %s on %s, expected %h actual %h",
               test_name, what, expected, actual);
      $display("** FAIL **");
      $fatal(1, "output check failed");
   endtask

   // every task starts and ends 1 time unit after a rising edge
   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // one-cycle command strobe where the address feeds ibus and aext for every code
   task automatic strobe(input cft_ctl_pkg::cmd_e code, input cft_bus_pkg::addr_t addr);
      cmd_valid = 1'b1;
      cmd_code  = code;
      ibus      = addr[15:0];
      aext      = addr[23:16];
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
      cmd_code  = cft_ctl_pkg::IDLE;
   endtask

   task automatic wait_done();
      int waited;
      waited = 0;
      while (cycle_done !== 1'b1) begin
         if (waited > CMD_CYCLES) begin
            $display("cycle_done never came in test %s", test_name);
            $display("** FAIL **");
            $fatal(1, "bus cycle did not finish");
         end
         @(posedge clk);
         #1;
         waited++;
      end
   endtask

   // register commands show their result two cycles after the strobe
   task automatic do_cmd(input cft_ctl_pkg::cmd_e code, input cft_bus_pkg::addr_t addr);
      strobe(code, addr);
      if (is_bus_cmd(code)) begin
         wait_done();
      end else begin
         idle(1);
      end
   endtask

   // start a bus cycle and strobe a second command while it is still busy
   task automatic drop_during(input cft_ctl_pkg::cmd_e bus_code,
                              input cft_ctl_pkg::cmd_e late_code, input int gap);
      strobe(bus_code, '0);
      idle(gap);
      strobe(late_code, 24'h77_8899);
      wait_done();
   endtask

   ////////////////////
   // reference model
   ////////////////////

   cft_bus_pkg::addr_t     m_ar;
   cft_bus_pkg::addr_t     pend_val;
   logic                   pend_load;
   logic                   pend_inc;
   int                     busy_left;
   int                     done_left;
   cft_ctl_pkg::cmd_e      m_kind;
   logic                   busy;
   logic                   accepted;
   logic                   drop_pend;
   cft_bus_pkg::addr_t     exp_ab;
   logic                   exp_ab_en;
   logic                   exp_mem_rd;
   logic                   exp_mem_wr;
   logic                   exp_io_rd;
   logic                   exp_io_wr;
   logic [3:0]             exp_dev_sel_n;
   logic                   exp_cycle_done;
   logic                   exp_cmd_drop;
   logic [`CFT_AEXT_W-1:0] exp_fpd;

   // busy covers the cycles N+1 to N+LEN after a bus strobe in cycle N
   assign busy     = (busy_left != 0);
   assign accepted = cmd_valid && !busy;

   // the model holds the values the outputs must have after each edge
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         m_ar           <= '0;
         pend_val       <= '0;
         pend_load      <= 1'b0;
         pend_inc       <= 1'b0;
         busy_left      <= 0;
         done_left      <= 0;
         m_kind         <= cft_ctl_pkg::IDLE;
         drop_pend      <= 1'b0;
         exp_ab         <= '0;
         exp_ab_en      <= 1'b0;
         exp_mem_rd     <= 1'b0;
         exp_mem_wr     <= 1'b0;
         exp_io_rd      <= 1'b0;
         exp_io_wr      <= 1'b0;
         exp_dev_sel_n  <= 4'hf;
         exp_cycle_done <= 1'b0;
         exp_cmd_drop   <= 1'b0;
      end else begin
         // register commands land one edge after they were taken
         if (pend_load) begin
            m_ar <= pend_val;
         end else if (pend_inc) begin
            m_ar <= m_ar + 24'd1;
         end
         pend_load <= accepted && (cmd_code == cft_ctl_pkg::LOAD_AR);
         pend_inc  <= accepted && (cmd_code == cft_ctl_pkg::INC_AR);
         pend_val  <= {aext, ibus};
         if (accepted && is_bus_cmd(cmd_code)) begin
            busy_left <= BUS_LEN;
            m_kind    <= cmd_code;
         end else if (busy) begin
            busy_left <= busy_left - 1;
         end
         // counts down to the done pulse in cycle N+LEN+2
         if (accepted && is_bus_cmd(cmd_code)) begin
            done_left <= BUS_LEN + 1;
         end else if (done_left != 0) begin
            done_left <= done_left - 1;
         end
         // bus side trails the busy window by one cycle
         exp_ab_en      <= busy;
         exp_ab         <= busy ? m_ar : '0;
         exp_mem_rd     <= busy && (m_kind == cft_ctl_pkg::MEM_RD);
         exp_mem_wr     <= busy && (m_kind == cft_ctl_pkg::MEM_WR);
         exp_io_rd      <= busy && (m_kind == cft_ctl_pkg::IO_RD);
         exp_io_wr      <= busy && (m_kind == cft_ctl_pkg::IO_WR);
         exp_dev_sel_n  <= (busy && (m_kind inside {cft_ctl_pkg::IO_RD, cft_ctl_pkg::IO_WR}))
                           ? group_select(m_ar) : 4'hf;
         exp_cycle_done <= (done_left == 1);
         // the drop flag comes two cycles after the lost strobe
         drop_pend      <= cmd_valid && busy;
         exp_cmd_drop   <= drop_pend;
      end
   end

   always_comb begin
      case (fp_sel)
         cft_ctl_pkg::FP_LOW: exp_fpd = m_ar[7:0];
         cft_ctl_pkg::FP_MID: exp_fpd = m_ar[15:8];
         default:             exp_fpd = m_ar[23:16];
      endcase
   end

   ////////////////////
   // output checks
   ////////////////////

   assert property (@(posedge clk) disable iff (!arst_n) ar == m_ar)
      else report_mismatch("ar", $sampled(m_ar), $sampled(ar));
   assert property (@(posedge clk) disable iff (!arst_n) ab == exp_ab)
      else report_mismatch("ab", $sampled(exp_ab), $sampled(ab));
   assert property (@(posedge clk) disable iff (!arst_n) ab_en == exp_ab_en)
      else report_mismatch("ab_en", $sampled(exp_ab_en), $sampled(ab_en));
   assert property (@(posedge clk) disable iff (!arst_n) mem_rd == exp_mem_rd)
      else report_mismatch("mem_rd", $sampled(exp_mem_rd), $sampled(mem_rd));
   assert property (@(posedge clk) disable iff (!arst_n) mem_wr == exp_mem_wr)
      else report_mismatch("mem_wr", $sampled(exp_mem_wr), $sampled(mem_wr));
   assert property (@(posedge clk) disable iff (!arst_n) io_rd == exp_io_rd)
      else report_mismatch("io_rd", $sampled(exp_io_rd), $sampled(io_rd));
   assert property (@(posedge clk) disable iff (!arst_n) io_wr == exp_io_wr)
      else report_mismatch("io_wr", $sampled(exp_io_wr), $sampled(io_wr));
   assert property (@(posedge clk) disable iff (!arst_n) dev_sel_n == exp_dev_sel_n)
      else report_mismatch("dev_sel_n", $sampled(exp_dev_sel_n), $sampled(dev_sel_n));
   assert property (@(posedge clk) disable iff (!arst_n) cycle_done == exp_cycle_done)
      else report_mismatch("cycle_done", $sampled(exp_cycle_done), $sampled(cycle_done));
   assert property (@(posedge clk) disable iff (!arst_n) cmd_drop == exp_cmd_drop)
      else report_mismatch("cmd_drop", $sampled(exp_cmd_drop), $sampled(cmd_drop));
   assert property (@(posedge clk) disable iff (!arst_n) fpd == exp_fpd)
      else report_mismatch("fpd", $sampled(exp_fpd), $sampled(fpd));

   ////////////////////
   // stimulus
   ////////////////////

   initial begin
      cft_ctl_pkg::cmd_e  kinds [4];
      cft_bus_pkg::addr_t r_addr;
      int                 r_code;
      seed      = 32'hf425_084d;
      arst_n    = 1'b0;
      cmd_valid = 1'b0;
      cmd_code  = cft_ctl_pkg::IDLE;
      ibus      = '0;
      aext      = '0;
      fp_sel    = cft_ctl_pkg::FP_LOW;
      test_name = "reset";
      kinds     = '{cft_ctl_pkg::MEM_RD, cft_ctl_pkg::MEM_WR,
                    cft_ctl_pkg::IO_RD, cft_ctl_pkg::IO_WR};
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;
      // outputs must sit at their reset values before any command
      idle(4);

      test_name = "load_inc";
      do_cmd(cft_ctl_pkg::LOAD_AR, 24'h12_3456);
      do_cmd(cft_ctl_pkg::INC_AR, '0);
      do_cmd(cft_ctl_pkg::INC_AR, '0);
      do_cmd(cft_ctl_pkg::LOAD_AR, 24'h00_ffff);
      do_cmd(cft_ctl_pkg::INC_AR, '0);
      // top of the address space rolls over to zero
      do_cmd(cft_ctl_pkg::LOAD_AR, 24'hff_ffff);
      do_cmd(cft_ctl_pkg::INC_AR, '0);

      test_name = "bus_cycle";
      for (int i = 0; i < 4; i++) begin
         do_cmd(cft_ctl_pkg::LOAD_AR, cft_bus_pkg::addr_t'($random(seed)));
         do_cmd(kinds[i], '0);
      end

      // every group value goes through an I/O cycle and then the same address through a
      // memory cycle
      // kinds holds the two memory codes first and the two I/O codes after them
      test_name = "io_decode";
      for (int g = 0; g < 8; g++) begin
         do_cmd(cft_ctl_pkg::LOAD_AR, {8'h5a, 5'd0, 3'(g), 8'h3c});
         do_cmd(kinds[2 + g[0]], '0);
         do_cmd(kinds[g[1]], '0);
      end
      // a nonzero high field keeps every group quiet
      do_cmd(cft_ctl_pkg::LOAD_AR, {8'h00, 5'h01, 3'd1, 8'h00});
      do_cmd(cft_ctl_pkg::IO_RD, '0);
      do_cmd(cft_ctl_pkg::LOAD_AR, {8'h00, 5'h10, 3'd0, 8'hff});
      do_cmd(cft_ctl_pkg::IO_WR, '0);
      do_cmd(cft_ctl_pkg::LOAD_AR, {8'hff, 5'h1f, 3'd3, 8'h80});
      do_cmd(cft_ctl_pkg::IO_RD, '0);

      test_name = "drop";
      do_cmd(cft_ctl_pkg::LOAD_AR, 24'h0a_0b0c);
      drop_during(cft_ctl_pkg::MEM_RD, cft_ctl_pkg::LOAD_AR, 0);
      drop_during(cft_ctl_pkg::IO_WR, cft_ctl_pkg::INC_AR, BUS_LEN - 1);
      drop_during(cft_ctl_pkg::MEM_WR, cft_ctl_pkg::IO_RD, 1);
      drop_during(cft_ctl_pkg::IO_RD, cft_ctl_pkg::IDLE, 2);

      test_name = "front_panel";
      do_cmd(cft_ctl_pkg::LOAD_AR, 24'hc3_a55a);
      for (int s = 0; s < 3; s++) begin
         fp_sel = cft_ctl_pkg::fp_sel_e'(s);
         idle(2);
      end

      // random gaps shorter than a bus cycle make some strobes land while busy
      test_name = "random";
      for (int i = 0; i < NUM_RANDOM; i++) begin
         r_code = {$random(seed)} % 7;
         r_addr = cft_bus_pkg::addr_t'($random(seed));
         if ({$random(seed)} % 2 == 0) begin
            r_addr[15:11] = 5'd0;
         end
         fp_sel = cft_ctl_pkg::fp_sel_e'({$random(seed)} % 3);
         strobe(cft_ctl_pkg::cmd_e'(r_code), r_addr);
         idle({$random(seed)} % (BUS_LEN + 3));
      end
      idle(CMD_CYCLES);

      $display("** PASS **");
      $finish;
   end

endmodule
